//--- Bender.yml
package:
  name: divunit

sources:
  - divCfgPkg.sv
  - divOpPkg.sv
  - lzc.sv
  - divPreproc.sv
  - divIter.sv
  - divPostproc.sv
  - divUnit.sv
  - target: test
    files:
      - tbDivUnit.sv

//--- divCfgPkg.sv
// Divider configuration package
// Width limits and the count-width helper shared by the integer divider datapath

package divCfgPkg;

  // Widest supported data path (RV64)
  localparam int maxXLen = 64;

  // Data width used when the top level is not overridden
  localparam int defaultXLen = 32;

  // Bits needed for a count that runs from 0 up to width inclusive
  function automatic int cntWidth(input int width);
    int w;
    w = 1;
    // Bounded by the widest supported datapath
    for (int i = 1; i <= $clog2(maxXLen + 1); i++) begin
      if ((1 << w) <= width) begin
        w = w + 1;
      end
    end
    return w;
  endfunction

endpackage

//--- divIter.sv
// Restoring radix-2 divide engine
// One quotient bit per cycle for steps+1 cycles, the divisor is walked right from
// its normalized position while the partial remainder shrinks

module divIter #(
  parameter int xLen = 32
) (
  input  logic                                    clk,
  input  logic                                    arstN,
  input  logic                                    load,
  input  logic                                    skip,
  input  logic [xLen-1:0]                         absA,
  input  logic [xLen-1:0]                         divisorNorm,
  input  logic [divCfgPkg::cntWidth(xLen)-1:0]    steps,
  output logic [xLen-1:0]                         quotRaw,
  output logic [xLen-1:0]                         remRaw,
  output logic                                    iterDone,
  output logic                                    busyIter
);

  localparam int CntW = divCfgPkg::cntWidth(xLen);

  logic              running;
  logic [CntW-1:0]   stepCnt;
  logic [xLen-1:0]   remReg;
  logic [xLen-1:0]   divReg;
  logic [xLen-1:0]   quotReg;
  logic [xLen-1:0]   remDiff;
  logic              fits;

  ////////////////////////////////////////
  // Step control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      running  <= 1'b0;
      iterDone <= 1'b0;
      stepCnt  <= '0;
    end else begin
      iterDone <= 1'b0;
      if (load) begin
        if (skip) begin
          // Early out, answer is already in the remainder register
          running  <= 1'b0;
          iterDone <= 1'b1;
        end else begin
          running <= 1'b1;
          stepCnt <= steps;
        end
      end else if (running) begin
        if (stepCnt == '0) begin
          running  <= 1'b0;
          iterDone <= 1'b1;
        end else begin
          stepCnt <= stepCnt - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Trial subtract
  assign fits    = remReg >= divReg;
  assign remDiff = remReg - divReg;

  always_ff @(posedge clk) begin
    if (load) begin
      remReg  <= absA;
      divReg  <= divisorNorm;
      quotReg <= '0;
    end else if (running) begin
      if (fits) begin
        remReg <= remDiff;
      end
      quotReg <= {quotReg[xLen-2:0], fits};
      divReg  <= divReg >> 1;
    end
  end

  assign quotRaw = quotReg;
  assign remRaw  = remReg;

  // Covers the setup cycle, the iterations and the handoff cycle
  assign busyIter = load | running | iterDone;

endmodule

//--- divOpPkg.sv
// Divider operation package
// Function code of the divide unit, RISC-V M funct3 encodings for the divide group

package divOpPkg;

  // Bit 2 is always set for the divide group
  // Bit 0 selects unsigned, bit 1 selects remainder
  typedef enum logic [2:0] {
    DIV  = 3'd4,
    DIVU = 3'd5,
    REM  = 3'd6,
    REMU = 3'd7
  } divOpT;

  // Operands taken as plain magnitudes
  function automatic logic isUnsigned(input divOpT op);
    return op[0];
  endfunction

  // Remainder word returned instead of quotient
  function automatic logic isRem(input divOpT op);
    return op[1];
  endfunction

endpackage

//--- divPostproc.sv
// Divide postprocessor
// Restores signs, applies the RISC-V divide-by-zero and overflow results,
// picks quotient or remainder and registers the final word

module divPostproc #(
  parameter int xLen = 32
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               iterDone,
  input  logic [xLen-1:0]    quotRaw,
  input  logic [xLen-1:0]    remRaw,
  input  divOpPkg::divOpT    op,
  input  logic               signA,
  input  logic               negQuot,
  input  logic               bZero,
  input  logic               overflow,
  input  logic [xLen-1:0]    srcAHeld,
  output logic [xLen-1:0]    result,
  output logic               done
);

  logic [xLen-1:0] quotSigned;
  logic [xLen-1:0] remSigned;
  logic [xLen-1:0] quotFinal;
  logic [xLen-1:0] remFinal;
  logic [xLen-1:0] resultNext;

  ////////////////////////////////////////
  // Sign restore
  ////////////////////////////////////////

  assign quotSigned = negQuot ? -quotRaw : quotRaw;
  // Remainder follows the dividend
  assign remSigned  = signA ? -remRaw : remRaw;

  ////////////////////////////////////////
  // Special cases and selection
  ////////////////////////////////////////

  always_comb begin
    quotFinal = quotSigned;
    remFinal  = remSigned;
    if (bZero) begin
      quotFinal = '1;
      remFinal  = srcAHeld;
    end else if (overflow) begin
      quotFinal = srcAHeld;
      remFinal  = '0;
    end
  end

  assign resultNext = divOpPkg::isRem(op) ? remFinal : quotFinal;

  // Result stays until the next operation completes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result <= '0;
      done   <= 1'b0;
    end else begin
      done <= iterDone;
      if (iterDone) begin
        result <= resultNext;
      end
    end
  end

endmodule

//--- divPreproc.sv
// Divide preprocessor
// Takes operand signs and magnitudes, measures the normalization distance between
// dividend and divisor, flags the early-out cases and registers the iteration setup
// when a new operation is accepted

module divPreproc #(
  parameter int xLen = 32
) (
  input  logic                                    clk,
  input  logic                                    arstN,
  input  logic                                    start,
  input  logic                                    busy,
  input  logic [xLen-1:0]                         srcA,
  input  logic [xLen-1:0]                         srcB,
  input  divOpPkg::divOpT                         op,
  output logic [xLen-1:0]                         absA,
  output logic [xLen-1:0]                         divisorNorm,
  output logic [divCfgPkg::cntWidth(xLen)-1:0]    steps,
  output logic                                    skip,
  output logic                                    bZero,
  output logic                                    signA,
  output logic                                    negQuot,
  output logic                                    overflow,
  output divOpPkg::divOpT                         opReg,
  output logic [xLen-1:0]                         srcAHeld,
  output logic                                    load
);

  localparam int CntW = divCfgPkg::cntWidth(xLen);

  logic              startGo;
  logic              isSigned;
  logic              sA;
  logic              sB;
  logic [xLen-1:0]   posA;
  logic [xLen-1:0]   posB;
  logic [CntW-1:0]   lzA;
  logic [CntW-1:0]   lzB;
  logic [CntW:0]     zeroDiff;
  logic [CntW-1:0]   pDist;
  logic              aLtB;
  logic              bZ;
  logic              skipCalc;
  logic              ovfCalc;

  // New operation only when the unit is idle
  assign startGo = start & ~busy;

  ////////////////////////////////////////
  // Signs and magnitudes
  ////////////////////////////////////////

  assign isSigned = ~divOpPkg::isUnsigned(op);
  assign sA       = srcA[xLen-1] & isSigned;
  assign sB       = srcB[xLen-1] & isSigned;
  assign posA     = sA ? -srcA : srcA;
  assign posB     = sB ? -srcB : srcB;

  // Most negative over minus one
  assign ovfCalc = isSigned & (srcA == {1'b1, {(xLen-1){1'b0}}}) & (&srcB);
  assign bZ      = ~(|srcB);

  ////////////////////////////////////////
  // Normalization distance
  ////////////////////////////////////////

  lzc #(.xLen(xLen)) lzcA_i (
    .in    (posA),
    .count (lzA)
  );

  lzc #(.xLen(xLen)) lzcB_i (
    .in    (posB),
    .count (lzB)
  );

  // Borrow out means the divisor reaches higher than the dividend
  assign zeroDiff = {1'b0, lzB} - {1'b0, lzA};
  assign aLtB     = zeroDiff[CntW];
  assign pDist    = zeroDiff[CntW-1:0];
  assign skipCalc = aLtB | bZ;

  ////////////////////////////////////////
  // Setup registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      load <= 1'b0;
    end else begin
      load <= startGo;
    end
  end

  // Captured once per accepted start, held through the whole operation
  always_ff @(posedge clk) begin
    if (startGo) begin
      absA     <= posA;
      // Divisor aligned to the dividend's top bit
      divisorNorm <= skipCalc ? posB : (posB << pDist);
      steps    <= skipCalc ? '0 : pDist;
      skip     <= skipCalc;
      bZero    <= bZ;
      signA    <= sA;
      negQuot  <= sA ^ sB;
      overflow <= ovfCalc;
      opReg    <= op;
      srcAHeld <= srcA;
    end
  end

endmodule

//--- divUnit.sv
// Iterative integer divide unit
// RISC-V DIV, DIVU, REM and REMU with variable latency, start strobe in,
// busy level and done pulse out

module divUnit #(
  parameter int xLen = divCfgPkg::defaultXLen
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               start,
  input  logic [xLen-1:0]    srcA,
  input  logic [xLen-1:0]    srcB,
  input  divOpPkg::divOpT    op,
  output logic [xLen-1:0]    result,
  output logic               busy,
  output logic               done
);

  localparam int CntW = divCfgPkg::cntWidth(xLen);

  // Preprocessor to engine
  logic [xLen-1:0]   absA;
  logic [xLen-1:0]   divisorNorm;
  logic [CntW-1:0]   steps;
  logic              skip;
  logic              load;

  // Preprocessor to postprocessor
  logic              bZero;
  logic              signA;
  logic              negQuot;
  logic              overflow;
  divOpPkg::divOpT   opReg;
  logic [xLen-1:0]   srcAHeld;

  // Engine to postprocessor
  logic [xLen-1:0]   quotRaw;
  logic [xLen-1:0]   remRaw;
  logic              iterDone;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  divPreproc #(.xLen(xLen)) divPreproc_i (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .busy        (busy),
    .srcA        (srcA),
    .srcB        (srcB),
    .op          (op),
    .absA        (absA),
    .divisorNorm (divisorNorm),
    .steps       (steps),
    .skip        (skip),
    .bZero       (bZero),
    .signA       (signA),
    .negQuot     (negQuot),
    .overflow    (overflow),
    .opReg       (opReg),
    .srcAHeld    (srcAHeld),
    .load        (load)
  );

  // Engine busy also covers the preprocessor's pending load
  divIter #(.xLen(xLen)) divIter_i (
    .clk         (clk),
    .arstN       (arstN),
    .load        (load),
    .skip        (skip),
    .absA        (absA),
    .divisorNorm (divisorNorm),
    .steps       (steps),
    .quotRaw     (quotRaw),
    .remRaw      (remRaw),
    .iterDone    (iterDone),
    .busyIter    (busy)
  );

  divPostproc #(.xLen(xLen)) divPostproc_i (
    .clk      (clk),
    .arstN    (arstN),
    .iterDone (iterDone),
    .quotRaw  (quotRaw),
    .remRaw   (remRaw),
    .op       (opReg),
    .signA    (signA),
    .negQuot  (negQuot),
    .bZero    (bZero),
    .overflow (overflow),
    .srcAHeld (srcAHeld),
    .result   (result),
    .done     (done)
  );

endmodule

//--- lzc.sv
// Leading-zero counter
// Returns the number of zeros above the highest set bit, xLen for an all-zero word

module lzc #(
  parameter int xLen = 32
) (
  input  logic [xLen-1:0]                         in,
  output logic [divCfgPkg::cntWidth(xLen)-1:0]    count
);

  localparam int CntW = divCfgPkg::cntWidth(xLen);

  ////////////////////////////////////////
  // Priority search
  ////////////////////////////////////////

  // Scan upward so the highest set bit wins
  always_comb begin
    count = CntW'(xLen);
    for (int i = 0; i < xLen; i++) begin
      if (in[i]) begin
        count = CntW'(xLen - 1 - i);
      end
    end
  end

endmodule

//--- tbDivUnit.sv
// Testbench for the iterative integer divide unit
// Directed tests for DIV, DIVU, REM and REMU against a reference model
// Also covers special cases, latency, the done pulse and start while busy

module tbDivUnit;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int xLen = 32;
  localparam logic [xLen-1:0] minNeg = {1'b1, {(xLen-1){1'b0}}};

  // Watchdog limit from a rough operation count of all tests
  localparam int opCount    = 440;
  localparam int cycleLimit = 60 * opCount;

  logic              clk;
  logic              arstN;
  logic              start;
  logic [xLen-1:0]   srcA;
  logic [xLen-1:0]   srcB;
  divOpPkg::divOpT   op;
  logic [xLen-1:0]   result;
  logic              busy;
  logic              done;

  int                cycleCount;

  divUnit #(.xLen(xLen)) divUnit_i (
    .clk    (clk),
    .arstN  (arstN),
    .start  (start),
    .srcA   (srcA),
    .srcB   (srcB),
    .op     (op),
    .result (result),
    .busy   (busy),
    .done   (done)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
      failRun();
    end
  end

  ////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////

  task automatic failRun();
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkResult(input string name, input logic [xLen-1:0] expWord,
                             input logic [xLen-1:0] actWord);
    if (expWord !== actWord) begin
      $display("[FAIL] %s expected %h actual %h", name, expWord, actWord);
      failRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic expBit, input logic actBit);
    if (expBit !== actBit) begin
      $display("[FAIL] %s expected %b actual %b", name, expBit, actBit);
      failRun();
    end
  endtask

  task automatic checkLatency(input string name, input int expCycles, input int actCycles);
    if (expCycles != actCycles) begin
      $display("[FAIL] %s expected %0d actual %0d", name, expCycles, actCycles);
      failRun();
    end
  endtask

  ////////////////////////////////////////
  // Reference model and drivers
  ////////////////////////////////////////

  // RISC-V M rules with division truncating toward zero
  task automatic refResult(input divOpPkg::divOpT o, input logic [xLen-1:0] a,
                           input logic [xLen-1:0] b, output logic [xLen-1:0] expWord);
    logic [xLen-1:0] q;
    logic [xLen-1:0] r;
    logic            signedOp;
    signedOp = (o == divOpPkg::DIV) || (o == divOpPkg::REM);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (signedOp && (a == minNeg) && (b == '1)) begin
      q = a;
      r = '0;
    end else if (signedOp) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    expWord = ((o == divOpPkg::REM) || (o == divOpPkg::REMU)) ? r : q;
  endtask

  // Zeros above the top set bit
  function automatic int leadZeros(input logic [xLen-1:0] w);
    int n;
    n = 0;
    while ((n < xLen) && !w[xLen-1-n]) begin
      n++;
    end
    return n;
  endfunction

  // Expected start to done cycles
  // An early out takes 3 and a full run p+4
  function automatic int expLatency(input divOpPkg::divOpT o, input logic [xLen-1:0] a,
                                    input logic [xLen-1:0] b);
    logic [xLen-1:0] magA;
    logic [xLen-1:0] magB;
    logic            signedOp;
    int              zerosA;
    int              zerosB;
    int              cycles;
    signedOp = (o == divOpPkg::DIV) || (o == divOpPkg::REM);
    magA     = (signedOp && a[xLen-1]) ? -a : a;
    magB     = (signedOp && b[xLen-1]) ? -b : b;
    zerosA   = leadZeros(magA);
    zerosB   = leadZeros(magB);
    // Divisor reaching above the dividend is the early out
    if ((b == '0) || (zerosB < zerosA)) begin
      cycles = 3;
    end else begin
      cycles = zerosB - zerosA + 4;
    end
    return cycles;
  endfunction

  // Latency counts rising edges from the one that drives start to done
  task automatic startOp(input divOpPkg::divOpT o, input logic [xLen-1:0] a,
                         input logic [xLen-1:0] b, output logic [xLen-1:0] res,
                         output int lat);
    @(posedge clk);
    start <= 1'b1;
    srcA  <= a;
    srcB  <= b;
    op    <= o;
    @(posedge clk);
    start <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!done) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    res = result;
  endtask

  // One operation against the model and the latency rule
  // Done must drop again right after
  task automatic checkOp(input string name, input divOpPkg::divOpT o,
                         input logic [xLen-1:0] a, input logic [xLen-1:0] b);
    logic [xLen-1:0] expWord;
    logic [xLen-1:0] res;
    int              lat;
    refResult(o, a, b, expWord);
    startOp(o, a, b, res, lat);
    checkResult(name, expWord, res);
    checkLatency({name, " latency"}, expLatency(o, a, b), lat);
    @(negedge clk);
    checkFlag({name, " done pulse"}, 1'b0, done);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic testUnsigned();
    logic [xLen-1:0] a;
    logic [xLen-1:0] b;
    logic [xLen-1:0] fixA [6] = '{32'd100, 32'd7, 32'hffff_ffff, 32'h8000_0000,
                                  32'd12345678, 32'hdead_beef};
    logic [xLen-1:0] fixB [6] = '{32'd7, 32'd7, 32'd1, 32'h0000_0003,
                                  32'd1000, 32'h0001_0000};
    for (int i = 0; i < 6; i++) begin
      checkOp("divu fixed", divOpPkg::DIVU, fixA[i], fixB[i]);
      checkOp("remu fixed", divOpPkg::REMU, fixA[i], fixB[i]);
    end
    // Shifted divisor spreads the normalization distance
    for (int i = 0; i < 200; i++) begin
      a = $urandom();
      b = $urandom() >> ($urandom() % 32);
      checkOp("divu random", divOpPkg::DIVU, a, b);
      checkOp("remu random", divOpPkg::REMU, a, b);
    end
  endtask

  task automatic testSigned();
    logic [xLen-1:0] sgnA [4] = '{32'd100, -32'd100, 32'd100, -32'd100};
    logic [xLen-1:0] sgnB [4] = '{32'd7, 32'd7, -32'd7, -32'd7};
    for (int i = 0; i < 4; i++) begin
      checkOp("div signs", divOpPkg::DIV, sgnA[i], sgnB[i]);
      checkOp("rem signs", divOpPkg::REM, sgnA[i], sgnB[i]);
    end
    checkOp("div large negative", divOpPkg::DIV, 32'h8000_0001, 32'd3);
    checkOp("rem large negative", divOpPkg::REM, 32'h8000_0001, 32'd3);
  endtask

  task automatic testDivByZero();
    checkOp("div by zero", divOpPkg::DIV, -32'd55, 32'd0);
    checkOp("divu by zero", divOpPkg::DIVU, 32'hcafe_0001, 32'd0);
    checkOp("rem by zero", divOpPkg::REM, -32'd55, 32'd0);
    checkOp("remu by zero", divOpPkg::REMU, 32'hcafe_0001, 32'd0);
  endtask

  task automatic testOverflow();
    checkOp("div overflow", divOpPkg::DIV, minNeg, '1);
    checkOp("rem overflow", divOpPkg::REM, minNeg, '1);
  endtask

  task automatic testSmallDividend();
    logic [xLen-1:0] res;
    int              lat;
    startOp(divOpPkg::DIVU, 32'd5, 32'd100, res, lat);
    checkResult("small dividend quotient", 32'd0, res);
    checkLatency("small dividend latency", 3, lat);
    startOp(divOpPkg::REMU, 32'd5, 32'd100, res, lat);
    checkResult("small dividend remainder", 32'd5, res);
    checkLatency("small dividend latency", 3, lat);
    startOp(divOpPkg::REM, -32'd5, 32'd100, res, lat);
    checkResult("small negative dividend", -32'd5, res);
  endtask

  task automatic testTiming();
    logic [xLen-1:0] res;
    logic [xLen-1:0] expWord;
    int              lat;
    // 0x100 over 3 gives p = 30 - 23 = 7
    startOp(divOpPkg::DIVU, 32'h100, 32'd3, res, lat);
    checkResult("latency p7 result", 32'd85, res);
    checkLatency("latency p7", 11, lat);
    // Equal leading zeros gives p = 0
    startOp(divOpPkg::DIVU, 32'd7, 32'd5, res, lat);
    checkResult("latency p0 result", 32'd1, res);
    checkLatency("latency p0", 4, lat);

    // Second start lands while busy and must be dropped
    refResult(divOpPkg::DIVU, 32'd1000, 32'd7, expWord);
    @(posedge clk);
    start <= 1'b1;
    srcA  <= 32'd1000;
    srcB  <= 32'd7;
    op    <= divOpPkg::DIVU;
    @(posedge clk);
    srcA  <= 32'hffff_ffff;
    srcB  <= 32'd3;
    op    <= divOpPkg::REMU;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    checkFlag("busy during operation", 1'b1, busy);
    while (!done) begin
      @(negedge clk);
    end
    checkResult("start while busy", expWord, result);
    repeat (70) begin
      @(negedge clk);
      checkFlag("no second done", 1'b0, done);
    end
    checkResult("result held", expWord, result);
    checkFlag("idle after operation", 1'b0, busy);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    arstN      = 1'b0;
    start      = 1'b0;
    srcA       = '0;
    srcB       = '0;
    op         = divOpPkg::DIVU;
    cycleCount = 0;
    void'($urandom(86));

    repeat (8) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkFlag("busy after reset", 1'b0, busy);
    checkFlag("done after reset", 1'b0, done);
    checkResult("result after reset", '0, result);

    testUnsigned();
    testSigned();
    testDivByZero();
    testOverflow();
    testSmallDividend();
    testTiming();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- verilog.f
divCfgPkg.sv
divOpPkg.sv
lzc.sv
divPreproc.sv
divIter.sv
divPostproc.sv
divUnit.sv
tbDivUnit.sv
